/* logic/fetchPkg.sv */
// shared types and constants for the instruction fetch stage
// every fetch module pulls these in with a wildcard import in its header
// widths, reset and interrupt vectors, ROM sizing and the bundles that
// travel between the sequencer, the ROM and the IF/ID register
package fetchPkg;

    // basic widths
    localparam int ADDR_WIDTH  = 32;
    localparam int INSTR_WIDTH = 16;
    localparam int OPCODE_BITS = 5;
    localparam int REG_BITS    = 3;
    localparam int SHAMT_BITS  = 5;

    // address and instruction word
    typedef logic [ADDR_WIDTH-1:0]  addrT;
    typedef logic [INSTR_WIDTH-1:0] instrT;

    // instruction fields
    // opcode 15:11, rs 10:8, rd 7:5, shamt 4:0
    typedef logic [OPCODE_BITS-1:0] opcodeT;
    typedef logic [REG_BITS-1:0]    regIdxT;
    typedef logic [SHAMT_BITS-1:0]  shamtT;
    // immediate is just the raw word
    typedef logic [INSTR_WIDTH-1:0] immT;

    // where the PC lands after reset and on an interrupt
    localparam addrT RESET_VECTOR = 32'h20;
    localparam addrT INT_VECTOR   = 32'h0;

    // ROM sizing, 1024 words, upper PC bits ignored so addresses wrap
    localparam int MEM_ADDR_BITS = 10;
    localparam string PROGRAM_FILE = "program.hex";

    // redirect requests coming back from later stages
    typedef struct packed {
        logic interrupt;
        logic returnPop;
        logic branch;
        logic jump;
        addrT popPc;
        addrT jumpAddress;
    } pcRedirectT;

    // contents of the IF/ID pipeline register
    typedef struct packed {
        addrT   nextAddress;
        opcodeT opCode;
        regIdxT rs;
        regIdxT rd;
        shamtT  shamt;
        immT    immValue;
    } ifIdT;

endpackage

/* logic/pcSequencer.sv */
// program counter and next-PC selection for the fetch stage
// reset (enable low) forces the reset vector; afterwards one of the
// interrupt vector, popped PC, jump target or PC+1 is loaded each clock
`timescale 1ns/1ns

module pcSequencer
    import fetchPkg::*;
(
    input  logic       clk,
    input  logic       enable,
    input  pcRedirectT redirect,
    output addrT       pc
);

    // current PC register
    addrT pcReg;
    // sequential successor of the current PC
    addrT pcPlusOne;
    // value to load at the next edge
    addrT nextPc;
    // branch and jump share the same target
    logic takeJump;

    assign pcPlusOne = pcReg + addrT'(1);
    assign takeJump  = redirect.branch | redirect.jump;

    // priority select
    // interrupt beats return, return beats branch/jump,
    // anything beats plain increment
    always_comb begin
        if (redirect.interrupt) begin
            nextPc = INT_VECTOR;
        end else if (redirect.returnPop) begin
            // address popped off the stack by the return
            nextPc = redirect.popPc;
        end else if (takeJump) begin
            nextPc = redirect.jumpAddress;
        end else begin
            nextPc = pcPlusOne;
        end
    end

    // PC register
    // async active-low reset to the reset vector
    always_ff @(posedge clk or negedge enable) begin
        if (!enable) begin
            pcReg <= RESET_VECTOR;
        end else begin
            // request seen now, new PC visible next cycle
            pcReg <= nextPc;
        end
    end

    // feeds the ROM and the IF/ID register
    assign pc = pcReg;

endmodule

/* logic/instructionMemory.sv */
// instruction ROM read at the current PC with no clock
// word addressed with one 16-bit instruction per location
// contents come from a hex image loaded at time zero
`timescale 1ns/1ns

module instructionMemory
    import fetchPkg::*;
(
    input  addrT  pc,
    output instrT instr
);

    // storage of 2**MEM_ADDR_BITS words
    instrT romWords [2 ** MEM_ADDR_BITS];

    // ROM index from the low bits of PC
    logic [MEM_ADDR_BITS-1:0] romIndex;

    // program image loaded once
    // entries not covered by the image read back as x in simulation
    initial begin
        $readmemh(PROGRAM_FILE, romWords);
    end

    // upper PC bits dropped so fetch wraps around the ROM
    assign romIndex = pc[MEM_ADDR_BITS-1:0];

    // async read
    // instr follows pc in the same cycle
    assign instr = romWords[romIndex];

endmodule

/* logic/ifIdRegister.sv */
// IF/ID pipeline register
// breaks the fetched word into opcode, rs, rd and shift fields,
// turns them into a bubble under load-immediate, branch or jump,
// and captures them with the raw word and PC+1 at each clock
`timescale 1ns/1ns

module ifIdRegister
    import fetchPkg::*;
(
    input  logic  clk,
    input  logic  enable,
    input  addrT  pc,
    input  instrT instr,
    input  logic  ldm,
    input  logic  branch,
    input  logic  jump,
    output ifIdT  ifId
);

    // word decoded this cycle, before the register
    ifIdT ifIdNext;
    // registered copy
    ifIdT ifIdReg;
    // current word must not reach decode as an instruction
    logic bubble;

    // ldm: the word is data for the previous instruction
    // branch/jump: the word is on the wrong path
    assign bubble = ldm | branch | jump;

    // field split and bubble zeroing
    always_comb begin
        ifIdNext.nextAddress = pc + addrT'(1);
        // raw word always travels as immediate
        ifIdNext.immValue = instr;
        if (bubble) begin
            ifIdNext.opCode = '0;
            ifIdNext.rs     = '0;
            ifIdNext.rd     = '0;
            ifIdNext.shamt  = '0;
        end else begin
            ifIdNext.opCode = instr[15:11];
            ifIdNext.rs     = instr[10:8];
            ifIdNext.rd     = instr[7:5];
            ifIdNext.shamt  = instr[4:0];
        end
    end

    // pipeline register, cleared while in reset
    always_ff @(posedge clk or negedge enable) begin
        if (!enable) begin
            ifIdReg <= '0;
        end else begin
            ifIdReg <= ifIdNext;
        end
    end

    assign ifId = ifIdReg;

endmodule

/* logic/fetchStage.sv */
// top of the instruction fetch stage
// sequencer picks the PC, the ROM returns the word at that PC,
// IF/ID register holds the decoded fields for the next stage
// all controls are plain levels sampled on the rising edge of clk
`timescale 1ns/1ns

module fetchStage
    import fetchPkg::*;
(
    input  logic       clk,
    input  logic       enable,
    input  pcRedirectT redirect,
    input  logic       ldm,
    output ifIdT       ifId
);

    // PC from the sequencer
    addrT pc;
    // word read at pc
    instrT instr;

    // program counter
    pcSequencer u_pcSequencer (
        .clk      (clk),
        .enable   (enable),
        .redirect (redirect),
        .pc       (pc)
    );

    // instruction ROM, read path only
    instructionMemory u_instructionMemory (
        .pc    (pc),
        .instr (instr)
    );

    // IF/ID capture
    // branch and jump bits double as bubble requests
    ifIdRegister u_ifIdRegister (
        .clk    (clk),
        .enable (enable),
        .pc     (pc),
        .instr  (instr),
        .ldm    (ldm),
        .branch (redirect.branch),
        .jump   (redirect.jump),
        .ifId   (ifId)
    );

endmodule

/* sim/fetchStage_checker.sv */
// concurrent assertions on the fetch stage
// bound into every fetchStage instance, watches the PC and the IF/ID output
`timescale 1ns/1ns

module fetchStageChecker
    import fetchPkg::*;
(
    input logic       clk,
    input logic       enable,
    input pcRedirectT redirect,
    input logic       ldm,
    input addrT       pc,
    input ifIdT       ifId
);

    // held on the reset vector during reset
    assert property (@(posedge clk) !enable |-> pc == RESET_VECTOR)
        else $error("pc left the reset vector while enable was low");

    // interrupt always wins
    assert property (@(posedge clk) disable iff (!enable)
        redirect.interrupt |=> pc == INT_VECTOR)
        else $error("pc did not go to the interrupt vector");

    // bubble clears the decoded fields
    assert property (@(posedge clk) disable iff (!enable)
        (ldm || redirect.branch || redirect.jump) |=>
        (ifId.opCode == '0 && ifId.rs == '0 && ifId.rd == '0 && ifId.shamt == '0))
        else $error("bubble did not clear the IF/ID fields");

endmodule

bind fetchStage fetchStageChecker u_fetchStageChecker (
    .clk      (clk),
    .enable   (enable),
    .redirect (redirect),
    .ldm      (ldm),
    .pc       (pc),
    .ifId     (ifId)
);

/* sim/fetchTb.sv */
// testbench for the instruction fetch stage
// drives random redirect and load-immediate levels from a seeded LCG,
// keeps its own PC and copy of the program image, and checks ifId and
// the PC after every clock; run from the project root so program.hex is found
`timescale 1ns/1ns

module fetchTb
    import fetchPkg::*;
();

    localparam int IMAGE_WORDS    = 48;
    localparam int RESET_CYCLES   = 10;
    localparam int STIM_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + 90;
    localparam logic [31:0] SEED  = 32'd46;

    logic       clk;
    logic       enable;
    pcRedirectT redirect;
    logic       ldm;
    ifIdT       ifId;

    // model state
    instrT       image [IMAGE_WORDS];
    addrT        modelPc;
    pcRedirectT  pending;
    logic        pendingLdm;
    logic [31:0] lcgState;
    int          cycleCount = 0;

    // how often the interesting cases came up
    int interruptSeen = 0;
    int returnSeen    = 0;
    int competingSeen = 0;
    int bubbleSeen    = 0;

    fetchStage u_fetchStage (
        .clk      (clk),
        .enable   (enable),
        .redirect (redirect),
        .ldm      (ldm),
        .ifId     (ifId)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareValue(string name, logic [63:0] expected, logic [63:0] actual);
        assert (actual === expected) else
            abortRun($sformatf("ERROR: %s expected %h, got %h", name, expected, actual));
    endtask

    // classic 32-bit LCG constants
    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // high about one time in eight, top bits only
    function automatic logic rareBit();
        logic [31:0] r;
        r = lcgNext();
        return r[31:29] == 3'b000;
    endfunction

    // somewhere inside the loaded image
    function automatic addrT randomTarget();
        logic [31:0] r;
        r = lcgNext();
        return addrT'(r[31:8] % IMAGE_WORDS);
    endfunction

    // PC after one edge: interrupt, then return, then branch or jump, then +1
    function automatic addrT nextPcOf(addrT pcNow, pcRedirectT rd);
        if (rd.interrupt)
            return INT_VECTOR;
        else if (rd.returnPop)
            return rd.popPc;
        else if (rd.branch || rd.jump)
            return rd.jumpAddress;
        else
            return pcNow + 32'd1;
    endfunction

    // what IF/ID should hold after an edge taken at pcNow
    function automatic ifIdT predictIfId(addrT pcNow, logic ldmNow, pcRedirectT rd);
        ifIdT  p;
        instrT word;
        word = image[pcNow[5:0]];
        p = '0;
        p.nextAddress = pcNow + 32'd1;
        p.immValue    = word;
        // bubble keeps the fields at zero
        if (!(ldmNow || rd.branch || rd.jump)) begin
            p.opCode = word[15:11];
            p.rs     = word[10:8];
            p.rd     = word[7:5];
            p.shamt  = word[4:0];
        end
        return p;
    endfunction

    task automatic noteCoverage(pcRedirectT rd, logic ldmNow);
        int requests;
        requests = int'(rd.interrupt) + int'(rd.returnPop) + int'(rd.branch | rd.jump);
        if (rd.interrupt)
            interruptSeen++;
        if (rd.returnPop)
            returnSeen++;
        if (requests > 1)
            competingSeen++;
        if (ldmNow || rd.branch || rd.jump)
            bubbleSeen++;
    endtask

    // new controls for the next edge
    task automatic drawStimulus(addrT pcNow, output pcRedirectT rd, output logic ldmNew);
        rd.interrupt   = rareBit();
        rd.returnPop   = rareBit();
        rd.branch      = rareBit();
        rd.jump        = rareBit();
        rd.popPc       = randomTarget();
        rd.jumpAddress = randomTarget();
        ldmNew         = rareBit();
        // keep fetch inside the image, past it the ROM is unloaded
        if (!(rd.interrupt || rd.returnPop || rd.branch || rd.jump) &&
            pcNow >= addrT'(IMAGE_WORDS - 1))
            rd.jump = 1'b1;
    endtask

    // run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
            abortRun("timeout: the test did not finish within the cycle limit");
    end

    initial begin
        ifIdT       expected;
        pcRedirectT newRd;
        logic       newLdm;
        enable     = 1'b1;
        redirect   = '0;
        ldm        = 1'b0;
        lcgState   = SEED;
        pending    = '0;
        pendingLdm = 1'b0;
        modelPc    = RESET_VECTOR;
        $readmemh(PROGRAM_FILE, image);

        // reset, ifId cleared and pc parked on the reset vector
        @(posedge clk);
        enable <= 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compareValue("ifId", 64'h0, 64'(ifId));
            compareValue("pc", 64'(RESET_VECTOR), 64'(u_fetchStage.pc));
            @(posedge clk);
        end
        enable <= 1'b1;

        for (int cycle = 0; cycle < STIM_CYCLES; cycle++) begin
            @(posedge clk);
            // this edge consumed pending controls at modelPc
            expected = predictIfId(modelPc, pendingLdm, pending);
            noteCoverage(pending, pendingLdm);
            modelPc = nextPcOf(modelPc, pending);
            drawStimulus(modelPc, newRd, newLdm);
            redirect   <= newRd;
            ldm        <= newLdm;
            pending    = newRd;
            pendingLdm = newLdm;

            @(negedge clk);
            // first capture after reset is the word at the reset vector
            if (cycle == 0)
                compareValue("ifId.nextAddress", 64'h21, 64'(ifId.nextAddress));
            compareValue("ifId.nextAddress", 64'(expected.nextAddress),
                64'(ifId.nextAddress));
            compareValue("ifId.opCode", 64'(expected.opCode), 64'(ifId.opCode));
            compareValue("ifId.rs", 64'(expected.rs), 64'(ifId.rs));
            compareValue("ifId.rd", 64'(expected.rd), 64'(ifId.rd));
            compareValue("ifId.shamt", 64'(expected.shamt), 64'(ifId.shamt));
            compareValue("ifId.immValue", 64'(expected.immValue), 64'(ifId.immValue));
            compareValue("pc", 64'(modelPc), 64'(u_fetchStage.pc));
        end

        assert (interruptSeen > 0) else abortRun("no interrupt request was generated");
        assert (returnSeen > 0) else abortRun("no return request was generated");
        assert (competingSeen > 0) else abortRun("no competing redirect requests occurred");
        assert (bubbleSeen > 0) else abortRun("no bubble cycle was generated");

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* program.hex */
// one 16-bit instruction word per line in hex, starting at word address 0
// fields: opcode 15:11, rs 10:8, rd 7:5, shift amount 4:0
0800
1125
2a4f
3b66
4c81
5d9a
6eb3
7fcc
8a15
9b2e
ac47
bd60
ce79
df92
e0ab
f1c4
0217
1330
2449
3562
467b
5794
68ad
79c6
8adf
9be8
ac01
bd1a
ce33
df4c
e065
f17e
a345
5c2f
1be8
c7d1
3f06
8e9a
64b3
d21c
27f5
b84e
0c63
f9a7
4d18
92e1
e6cb
7034

/* sources.f */
logic/fetchPkg.sv
logic/pcSequencer.sv
logic/instructionMemory.sv
logic/ifIdRegister.sv
logic/fetchStage.sv
sim/fetchStage_checker.sv
sim/fetchTb.sv

/* Makefile */
# Verilator build and run of the fetch stage testbench
# the run target fails when the simulation ends in $fatal or an assertion

SOURCES := $(shell cat sources.f)
SIM     := obj_dir/VfetchTb

.PHONY: all run clean

all: run

$(SIM): sources.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module fetchTb -f sources.f -o VfetchTb

run: $(SIM) program.hex
	./$(SIM)

clean:
	rm -rf obj_dir
